// ==== all.f ====
+incdir+include
rtl/soc_pkg.sv
rtl/ahb_decoder.sv
rtl/tcm_ram.sv
rtl/gpio_ctrl.sv
rtl/soc_bus_top.sv
tb/tb_clk_gen.sv
tb/soc_checker.sv
tb/tb_soc.sv

// ==== Makefile ====
# Verilator build and run of the bus fabric testbench
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_soc.sv ====
// Single AHB-lite master, one transfer per table row; RAM words are written before they are read
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc;
   import soc_pkg::*;

   localparam int MAX_ROWS      = 32;
   localparam int READY_TIMEOUT = 16;   // Cycles
   localparam int RESET_TIMEOUT = 20;
   localparam int K_RAM         = 0;    // Row kinds
   localparam int K_GPIO        = 1;
   localparam int K_ERR         = 2;
   localparam word_t GPIO_OUT   = `SOC_GPIO_BASE + 32'(`SOC_GPIO_OUT_OFS);
   localparam word_t GPIO_IN    = `SOC_GPIO_BASE + 32'(`SOC_GPIO_IN_OFS);

   logic                   clk;
   logic                   rst_n;
   word_t                  haddr;
   htrans_t                htrans;
   logic                   hwrite;
   hsize_t                 hsize;
   word_t                  hwdata;
   word_t                  hrdata;
   logic                   hready;
   logic                   hresp;
   logic [`SOC_GPIO_W-1:0] p0;
   logic [`SOC_GPIO_W-1:0] p1;

   // Expectations for the checker
   logic                   exp_valid;
   int                     exp_tag;
   word_t                  exp_rdata;
   logic                   exp_chk;
   logic                   exp_resp;
   int                     exp_waits;
   logic [`SOC_GPIO_W-1:0] exp_p0;
   int                     chk_errs;
   int                     chk_done;

   // Stimulus table
   word_t                  t_addr  [MAX_ROWS];
   logic                   t_wr    [MAX_ROWS];
   hsize_t                 t_size  [MAX_ROWS];
   word_t                  t_wdata [MAX_ROWS];
   word_t                  t_rdata [MAX_ROWS];
   logic                   t_chk   [MAX_ROWS];
   logic                   t_resp  [MAX_ROWS];
   int                     t_waits [MAX_ROWS];
   int                     t_idle  [MAX_ROWS];   // Idle cycles before the address phase
   logic [`SOC_GPIO_W-1:0] t_p1    [MAX_ROWS];
   logic [`SOC_GPIO_W-1:0] t_p0    [MAX_ROWS];   // P0 after the row
   int                     n_rows;

   word_t                  ram_sh [logic [29:0]];   // Shadow RAM by word address
   logic [`SOC_GPIO_W-1:0] gpio_sh;
   logic [`SOC_GPIO_W-1:0] p1_val;
   integer                 seed;
   int                     other_errs;
   logic                   timed_out;

   tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(4)) u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   soc_bus_top UUT (
      .clk    (clk),
      .rst_n  (rst_n),
      .haddr  (haddr),
      .htrans (htrans),
      .hwrite (hwrite),
      .hsize  (hsize),
      .hwdata (hwdata),
      .hrdata (hrdata),
      .hready (hready),
      .hresp  (hresp),
      .P0     (p0),
      .P1     (p1)
   );

   soc_checker u_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .p0        (p0),
      .exp_valid (exp_valid),
      .exp_tag   (exp_tag),
      .exp_rdata (exp_rdata),
      .exp_chk   (exp_chk),
      .exp_resp  (exp_resp),
      .exp_waits (exp_waits),
      .exp_p0    (exp_p0),
      .err_cnt   (chk_errs),
      .done_cnt  (chk_done)
   );

   function automatic word_t rand_word();
      rand_word = $random(seed);
   endfunction

   // Appends one row, expected values follow the address map and AHB byte lanes
   task automatic add_row(input word_t addr, input logic wr, input hsize_t size,
                          input word_t wdata, input int kind, input int idle);
      word_t       cur;
      logic [3:0]  lanes;
      logic [11:0] ofs;
      int          lo;
      ofs = addr[11:0];
      lo  = int'(addr[1:0]);   // First byte of the transfer
      cur = '0;
      t_addr[n_rows]  = addr;
      t_wr[n_rows]    = wr;
      t_size[n_rows]  = size;
      t_wdata[n_rows] = wdata;
      t_rdata[n_rows] = '0;
      t_chk[n_rows]   = !wr && (kind != K_ERR);
      t_resp[n_rows]  = (kind == K_ERR);
      t_waits[n_rows] = (kind == K_RAM) ? 0 : 1;   // GPIO and ERROR stall once
      t_idle[n_rows]  = idle;
      t_p1[n_rows]    = p1_val;
      if (kind == K_RAM) begin
         if (ram_sh.exists(addr[31:2]))
            cur = ram_sh[addr[31:2]];
         for (int b = 0; b < 4; b++)   // Bytes from addr up to addr plus size
            lanes[b] = (b >= lo) && (b < lo + (1 << size));
         if (wr) begin
            for (int b = 0; b < 4; b++) begin
               if (lanes[b])
                  cur[8*b +: 8] = wdata[8*b +: 8];
            end
            ram_sh[addr[31:2]] = cur;
         end else begin
            t_rdata[n_rows] = cur;
         end
      end else if (kind == K_GPIO) begin
         if (wr && (ofs == `SOC_GPIO_OUT_OFS))
            gpio_sh = wdata[`SOC_GPIO_W-1:0];   // Writes to IN are dropped
         else if (!wr && (ofs == `SOC_GPIO_OUT_OFS))
            t_rdata[n_rows] = word_t'(gpio_sh);
         else if (!wr && (ofs == `SOC_GPIO_IN_OFS))
            t_rdata[n_rows] = word_t'(p1_val);
      end
      t_p0[n_rows] = gpio_sh;
      n_rows++;
   endtask

   task automatic build_table();
      word_t r;
      n_rows  = 0;
      gpio_sh = '0;
      p1_val  = '0;
      // Banks differ only in bit 16, back to back
      add_row(32'h0000_0100, 1'b1, WORD, rand_word(), K_RAM, 0);
      add_row(32'h0001_0100, 1'b1, WORD, rand_word(), K_RAM, 0);
      add_row(32'h0000_0100, 1'b0, WORD, 32'h0, K_RAM, 0);
      add_row(32'h0001_0100, 1'b0, WORD, 32'h0, K_RAM, 0);
      add_row(32'h0000_0200, 1'b1, WORD, rand_word(), K_RAM, 0);
      add_row(32'h0000_0200, 0, WORD, 32'h0, K_RAM, 0);   // Read right after write
      add_row(32'h0001_0204, 1'b1, WORD, rand_word(), K_RAM, 0);
      add_row(32'h0001_0204, 1'b0, WORD, 32'h0, K_RAM, 0);
      // Sub-word lanes merged into a word
      add_row(32'h0000_0300, 1'b1, WORD, rand_word(), K_RAM, 2);
      add_row(32'h0000_0301, 1'b1, BYTE, rand_word(), K_RAM, 0);
      add_row(32'h0000_0302, 1'b1, HALF, rand_word(), K_RAM, 0);
      add_row(32'h0000_0300, 1'b0, WORD, 32'h0, K_RAM, 0);
      add_row(32'h0001_0308, 1'b1, WORD, rand_word(), K_RAM, 1);
      add_row(32'h0001_030b, 1'b1, BYTE, rand_word(), K_RAM, 0);
      add_row(32'h0001_0308, 1'b1, HALF, rand_word(), K_RAM, 0);
      add_row(32'h0001_0308, 1'b0, WORD, 32'h0, K_RAM, 0);
      // GPIO, one wait state each
      add_row(GPIO_OUT, 1'b1, WORD, rand_word(), K_GPIO, 1);
      add_row(GPIO_OUT, 1'b0, WORD, 32'h0, K_GPIO, 0);
      r = rand_word();
      p1_val = r[`SOC_GPIO_W-1:0];
      add_row(GPIO_IN, 1'b0, WORD, 32'h0, K_GPIO, 4);   // P1 held 4 cycles first
      add_row(GPIO_IN, 1'b1, WORD, rand_word(), K_GPIO, 0);
      add_row(`SOC_GPIO_BASE + 32'h8, 1'b0, WORD, 32'h0, K_GPIO, 0);
      add_row(32'h0000_0100, 1'b0, WORD, 32'h0, K_RAM, 0);
      // Unmapped, low bits alias RAM and GPIO OUT
      add_row(32'h0002_0100, 1'b1, WORD, rand_word(), K_ERR, 1);
      add_row(32'h2000_1000, 1'b1, WORD, rand_word(), K_ERR, 0);
      add_row(32'h3000_0000, 1'b0, WORD, 32'h0, K_ERR, 0);
      add_row(32'h0000_0100, 1'b0, WORD, 32'h0, K_RAM, 0);
      add_row(32'h0001_0100, 1'b0, WORD, 32'h0, K_RAM, 0);
      add_row(GPIO_OUT, 1'b0, WORD, 32'h0, K_GPIO, 0);
   endtask

   // Returns on the falling edge of the cycle that ends with hready high
   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk);
      while ((hready !== 1'b1) && (n < READY_TIMEOUT)) begin
         @(negedge clk);
         n++;
      end
      if (hready !== 1'b1) begin
         $display("Timeout: hready stayed low for %0d cycles at t=%0t", n, $time);
         other_errs++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (!rst_n && (n < RESET_TIMEOUT)) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) begin
         $display("Timeout: reset was never released");
         other_errs++;
         timed_out = 1'b1;
      end
   endtask

   // Each step drives the data phase of pend and the address phase of the next row
   task automatic run_table();
      int i;
      int pend;
      int issued;
      int idle_left;
      i         = 0;
      pend      = -1;
      idle_left = t_idle[0];
      p1        = t_p1[0];
      while (((i < n_rows) || (pend >= 0)) && !timed_out) begin
         if (pend >= 0) begin
            hwdata    = t_wdata[pend];
            exp_valid = 1'b1;
            exp_tag   = pend;
            exp_rdata = t_rdata[pend];
            exp_chk   = t_chk[pend];
            exp_resp  = t_resp[pend];
            exp_waits = t_waits[pend];
         end else begin
            exp_valid = 1'b0;
         end
         if ((i < n_rows) && (idle_left == 0)) begin
            haddr  = t_addr[i];
            hwrite = t_wr[i];
            hsize  = t_size[i];
            htrans = NONSEQ;
            issued = i;
         end else begin
            htrans = IDLE;
            issued = -1;
            if (i < n_rows)
               idle_left--;
         end
         wait_ready();   // Address held while stalled
         @(posedge clk);
         #1;
         if (pend >= 0)
            exp_p0 = t_p0[pend];   // OUT lands on the completing edge
         pend = issued;
         if (issued >= 0) begin
            i++;
            if (i < n_rows) begin
               idle_left = t_idle[i];
               p1        = t_p1[i];
            end
         end
      end
      htrans    = IDLE;
      exp_valid = 1'b0;
   endtask

   task automatic finish_run();
      if (chk_done != n_rows) begin
         $display("Only %0d of %0d transfers completed", chk_done, n_rows);
         other_errs++;
      end
      $display("Error count: %0d mismatches, %0d other, %0d transfers checked",
               chk_errs, other_errs, chk_done);
      if ((chk_errs + other_errs) == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   endtask

   initial begin
      haddr      = '0;
      htrans     = IDLE;
      hwrite     = 1'b0;
      hsize      = WORD;
      hwdata     = '0;
      p1         = '0;
      exp_valid  = 1'b0;
      exp_tag    = 0;
      exp_rdata  = '0;
      exp_chk    = 1'b0;
      exp_resp   = 1'b0;
      exp_waits  = 0;
      exp_p0     = '0;   // P0 clears on reset
      other_errs = 0;
      timed_out  = 1'b0;
      seed       = 32'h2d1f_67e0;
      build_table();
      wait_reset();
      if (!timed_out) begin
         repeat (3) @(posedge clk);   // Idle bus after reset
         #1;
         run_table();
         repeat (3) @(posedge clk);
      end
      finish_run();
   end

endmodule

// ==== tb/soc_checker.sv ====
// Samples on the falling edge; relies on the master driving inputs and expectations after the rising edge
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_checker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  soc_pkg::word_t         hrdata,
   input  logic                   hready,
   input  logic                   hresp,
   input  logic [`SOC_GPIO_W-1:0] p0,
   input  logic                   exp_valid,   // A data phase is in progress
   input  int                     exp_tag,     // Table row of that data phase
   input  soc_pkg::word_t         exp_rdata,
   input  logic                   exp_chk,     // Compare hrdata
   input  logic                   exp_resp,
   input  int                     exp_waits,   // Cycles with hready low
   input  logic [`SOC_GPIO_W-1:0] exp_p0,
   output int                     err_cnt,
   output int                     done_cnt     // Completed data phases
);

   int waits;   // Low-ready cycles of the current data phase

   task automatic flag_mismatch(input string sig, input int row, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("MISMATCH t=%0t %s (row %0d): got 0x%08h, expected 0x%08h",
               $time, sig, row, got, exp);
      err_cnt++;
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         err_cnt  = 0;
         done_cnt = 0;
         waits    = 0;
      end else begin
         if (p0 !== exp_p0)   // P0 follows the last OUT write
            flag_mismatch("P0", exp_tag, 32'(p0), 32'(exp_p0));
         if (!exp_valid) begin
            // Idle bus, ready and OKAY
            if (hready !== 1'b1)
               flag_mismatch("hready", -1, 32'(hready), 32'h1);
            if (hresp !== 1'b0)
               flag_mismatch("hresp", -1, 32'(hresp), 32'h0);
         end else if (hready !== 1'b1) begin
            waits++;
            if (hresp !== exp_resp)   // ERROR already on the first cycle
               flag_mismatch("hresp", exp_tag, 32'(hresp), 32'(exp_resp));
         end else begin
            if (hresp !== exp_resp)
               flag_mismatch("hresp", exp_tag, 32'(hresp), 32'(exp_resp));
            if (waits != exp_waits)
               flag_mismatch("hready wait cycles", exp_tag, waits, exp_waits);
            if (exp_chk && (hrdata !== exp_rdata))
               flag_mismatch("hrdata", exp_tag, hrdata, exp_rdata);
            waits = 0;
            done_cnt++;
         end
      end
   end

endmodule

// ==== tb/tb_clk_gen.sv ====
// 8 ns free-running clock; rst_n low from time zero, released 1 ns after the fourth rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 8,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Power-on reset only
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;   // Off the clock edge
   end

endmodule

// ==== rtl/soc_bus_top.sv ====
// Single AHB-lite slave port, NONSEQ only; P0 is a pure output and P1 a pure asynchronous input
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_bus_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  soc_pkg::word_t         haddr,
   input  soc_pkg::htrans_t       htrans,
   input  logic                   hwrite,
   input  soc_pkg::hsize_t        hsize,
   input  soc_pkg::word_t         hwdata,
   output soc_pkg::word_t         hrdata,
   output logic                   hready,
   output logic                   hresp,
   output logic [`SOC_GPIO_W-1:0] P0,
   input  logic [`SOC_GPIO_W-1:0] P1
);
   import soc_pkg::*;

   logic  sel_tcm0;
   logic  sel_tcm1;
   logic  sel_gpio;
   word_t tcm0_rdata;
   word_t tcm1_rdata;
   word_t gpio_rdata;
   logic  tcm0_ready;
   logic  tcm1_ready;
   logic  gpio_ready;

   ahb_decoder u_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .haddr      (haddr),
      .htrans     (htrans),
      .hwrite     (hwrite),
      .hsize      (hsize),
      .sel_tcm0   (sel_tcm0),
      .sel_tcm1   (sel_tcm1),
      .sel_gpio   (sel_gpio),
      .tcm0_rdata (tcm0_rdata),
      .tcm1_rdata (tcm1_rdata),
      .gpio_rdata (gpio_rdata),
      .tcm0_ready (tcm0_ready),
      .tcm1_ready (tcm1_ready),
      .gpio_ready (gpio_ready),
      .hrdata     (hrdata),
      .hready     (hready),
      .hresp      (hresp)
   );

   // Bank 0 at 0x0000_0000
   tcm_ram #(.AW(`SOC_TCM_AW)) u_tcm0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .sel      (sel_tcm0),
      .haddr    (haddr),
      .hwrite   (hwrite),
      .hsize    (hsize),
      .hwdata   (hwdata),
      .rdata    (tcm0_rdata),
      .readyout (tcm0_ready)
   );

   // Bank 1 at 0x0001_0000
   tcm_ram #(.AW(`SOC_TCM_AW)) u_tcm1 (
      .clk      (clk),
      .rst_n    (rst_n),
      .sel      (sel_tcm1),
      .haddr    (haddr),
      .hwrite   (hwrite),
      .hsize    (hsize),
      .hwdata   (hwdata),
      .rdata    (tcm1_rdata),
      .readyout (tcm1_ready)
   );

   gpio_ctrl u_gpio (
      .clk      (clk),
      .rst_n    (rst_n),
      .sel      (sel_gpio),
      .haddr    (haddr),
      .hwrite   (hwrite),
      .hwdata   (hwdata),
      .rdata    (gpio_rdata),
      .readyout (gpio_ready),
      .gpio_out (P0),
      .gpio_in  (P1)
   );

endmodule

// ==== rtl/gpio_ctrl.sv ====
// One wait state per access, hsize ignored so a write to OUT always takes hwdata[15:0]
`timescale 1ns/1ps
`include "soc_params.svh"

module gpio_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sel,
   input  soc_pkg::word_t         haddr,
   input  logic                   hwrite,
   input  soc_pkg::word_t         hwdata,
   output soc_pkg::word_t         rdata,
   output logic                   readyout,
   output logic [`SOC_GPIO_W-1:0] gpio_out,
   input  logic [`SOC_GPIO_W-1:0] gpio_in
);

   logic                        wait_q;   // First data-phase cycle
   logic                        dp_q;     // Data phase in progress
   logic                        wr_q;
   logic [`SOC_GPIO_WIN_AW-1:0] ofs_q;    // Offset within the window
   logic [`SOC_GPIO_W-1:0]      sync1_q;
   logic [`SOC_GPIO_W-1:0]      sync2_q;
   logic [`SOC_GPIO_W-1:0]      in_q;     // IN register
   logic                        out_wr;

   // Wait state counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_q <= 1'b0;
         dp_q   <= 1'b0;
      end else if (sel) begin
         wait_q <= 1'b1;
         dp_q   <= 1'b1;
      end else if (wait_q) begin
         wait_q <= 1'b0;
      end else begin
         dp_q   <= 1'b0;
      end
   end

   assign readyout = !wait_q;

   always_ff @(posedge clk) begin
      if (sel) begin
         wr_q  <= hwrite;
         ofs_q <= haddr[`SOC_GPIO_WIN_AW-1:0];
      end
   end

   // Commit on the ready cycle
   assign out_wr = dp_q && !wait_q && wr_q && (ofs_q == `SOC_GPIO_OUT_OFS);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gpio_out <= '0;
         sync1_q  <= '0;
         sync2_q  <= '0;
         in_q     <= '0;
      end else begin
         if (out_wr)
            gpio_out <= hwdata[`SOC_GPIO_W-1:0];
         sync1_q <= gpio_in;   // P1 is asynchronous
         sync2_q <= sync1_q;
         in_q    <= sync2_q;
      end
   end

   // Read mux, zero-extended
   always_comb begin
      rdata = '0;
      if (ofs_q == `SOC_GPIO_OUT_OFS)
         rdata[`SOC_GPIO_W-1:0] = gpio_out;
      else if (ofs_q == `SOC_GPIO_IN_OFS)
         rdata[`SOC_GPIO_W-1:0] = in_q;
   end

   // Exactly one wait state
   a_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
      !readyout |=> readyout);

endmodule

// ==== rtl/tcm_ram.sv ====
// Zero wait state RAM bank; only the low AW address bits are used, accesses must be aligned
`timescale 1ns/1ps
`include "soc_params.svh"

module tcm_ram #(
   parameter int AW = `SOC_TCM_AW   // Byte address bits
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            sel,
   input  soc_pkg::word_t  haddr,
   input  logic            hwrite,
   input  soc_pkg::hsize_t hsize,
   input  soc_pkg::word_t  hwdata,
   output soc_pkg::word_t  rdata,
   output logic            readyout
);
   import soc_pkg::*;

   localparam int WW = AW - 2;   // Word index bits

   word_t         mem [0:(2**WW)-1];
   logic [WW-1:0] word_idx;
   be_t           lane_mask;     // Lanes of the current address phase
   logic          we_q;          // Write pending in data phase
   logic [WW-1:0] wa_q;
   be_t           mask_q;
   word_t         rd_q;          // Array read taken at end of address phase
   logic          byp_q;         // Previous write hit the word being read
   word_t         byp_data_q;
   be_t           byp_mask_q;

   assign word_idx = haddr[AW-1:2];

   // Byte lanes from size and low address bits
   always_comb begin
      case (hsize)
         BYTE:    lane_mask = be_t'(4'b0001 << haddr[1:0]);
         HALF:    lane_mask = haddr[1] ? 4'b1100 : 4'b0011;
         default: lane_mask = 4'b1111;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         we_q  <= 1'b0;
         byp_q <= 1'b0;
      end else begin
         we_q  <= sel && hwrite;
         byp_q <= sel && we_q && (wa_q == word_idx);   // Write lands on the same edge
      end
   end

   // Array and payload registers
   always_ff @(posedge clk) begin
      if (sel) begin
         wa_q   <= word_idx;
         mask_q <= lane_mask;
         rd_q   <= mem[word_idx];
      end
      byp_data_q <= hwdata;
      byp_mask_q <= mask_q;
      if (we_q) begin
         for (int i = 0; i < 4; i++) begin
            if (mask_q[i])
               mem[wa_q][8*i +: 8] <= hwdata[8*i +: 8];   // Data phase write
         end
      end
   end

   // Merge bypassed lanes over the array word
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         if (byp_q && byp_mask_q[i])
            rdata[8*i +: 8] = byp_data_q[8*i +: 8];
         else
            rdata[8*i +: 8] = rd_q[8*i +: 8];
      end
   end

   assign readyout = 1'b1;   // Never stalls

   // Natural alignment for each size
   a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      sel |-> ((hsize == HALF) ? !haddr[0] :
               (hsize == WORD) ? (haddr[1:0] == 2'b00) : 1'b1));

endmodule

// ==== rtl/ahb_decoder.sv ====
// Single master only; unmapped addresses and sizes above WORD get the two-cycle ERROR response
`timescale 1ns/1ps
`include "soc_params.svh"

module ahb_decoder (
   input  logic             clk,
   input  logic             rst_n,
   // Address phase from the master
   input  soc_pkg::word_t   haddr,
   input  soc_pkg::htrans_t htrans,
   input  logic             hwrite,
   input  soc_pkg::hsize_t  hsize,
   // Slave selects
   output logic             sel_tcm0,
   output logic             sel_tcm1,
   output logic             sel_gpio,
   // Slave responses
   input  soc_pkg::word_t   tcm0_rdata,
   input  soc_pkg::word_t   tcm1_rdata,
   input  soc_pkg::word_t   gpio_rdata,
   input  logic             tcm0_ready,
   input  logic             tcm1_ready,
   input  logic             gpio_ready,
   // Response to the master
   output soc_pkg::word_t   hrdata,
   output logic             hready,
   output logic             hresp
);
   import soc_pkg::*;

   typedef enum logic {
      ES_OKAY,   // No error, or first error cycle pending
      ES_LAST    // Second error cycle, hready back high
   } err_state_t;

   localparam word_t TCM0_BASE = `SOC_TCM0_BASE;
   localparam word_t TCM1_BASE = `SOC_TCM1_BASE;
   localparam word_t GPIO_BASE = `SOC_GPIO_BASE;

   region_t    addr_region;   // Region of the current address phase
   region_t    dp_region;     // Region of the transfer in data phase
   logic       dp_valid;      // A data phase is in progress
   logic       accept;
   logic       err_first;
   err_state_t err_state;

   // Address decode, bad size counts as unmapped
   always_comb begin
      addr_region = REG_NONE;
      if (hsize <= WORD) begin
         if (haddr[31:`SOC_TCM_AW] == TCM0_BASE[31:`SOC_TCM_AW])
            addr_region = REG_TCM0;
         else if (haddr[31:`SOC_TCM_AW] == TCM1_BASE[31:`SOC_TCM_AW])
            addr_region = REG_TCM1;
         else if (haddr[31:`SOC_GPIO_WIN_AW] == GPIO_BASE[31:`SOC_GPIO_WIN_AW])
            addr_region = REG_GPIO;
      end
   end

   assign accept   = (htrans == NONSEQ) && hready;   // SEQ and BUSY act as idle
   assign sel_tcm0 = accept && (addr_region == REG_TCM0);
   assign sel_tcm1 = accept && (addr_region == REG_TCM1);
   assign sel_gpio = accept && (addr_region == REG_GPIO);

   // Data phase tracking, advances only when the bus is ready
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_valid  <= 1'b0;
         dp_region <= REG_NONE;
      end else if (hready) begin
         dp_valid  <= (htrans == NONSEQ);
         dp_region <= addr_region;
      end
   end

   // First error cycle, held until the machine moves on
   assign err_first = dp_valid && (dp_region == REG_NONE) && (err_state == ES_OKAY);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         err_state <= ES_OKAY;
      else
         err_state <= err_first ? ES_LAST : ES_OKAY;
   end

   // Response mux from the registered region
   always_comb begin
      hrdata = '0;
      hready = 1'b1;   // Idle bus stays ready
      hresp  = err_first || (err_state == ES_LAST);
      if (err_first) begin
         hready = 1'b0;
      end else if (dp_valid) begin
         case (dp_region)
            REG_TCM0: begin
               hrdata = tcm0_rdata;
               hready = tcm0_ready;
            end
            REG_TCM1: begin
               hrdata = tcm1_rdata;
               hready = tcm1_ready;
            end
            REG_GPIO: begin
               hrdata = gpio_rdata;
               hready = gpio_ready;
            end
            default: hready = 1'b1;   // Last error cycle
         endcase
      end
   end

   // At most one slave per address phase
   a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({sel_tcm0, sel_tcm1, sel_gpio}));

   // Accepted unmapped transfer opens with low ready and ERROR
   a_err_first: assert property (@(posedge clk) disable iff (!rst_n)
      (accept && (addr_region == REG_NONE)) |=> (!hready && hresp));

   // Second ERROR cycle, ready back high
   a_err_last: assert property (@(posedge clk) disable iff (!rst_n)
      (!hready && hresp) |=> (hready && hresp));

   // Master keeps a stalled address phase stable
   a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (htrans == NONSEQ) && !hready |=>
         ($stable(haddr) && $stable(hwrite) && $stable(hsize)) || (htrans == IDLE));

endmodule

// ==== rtl/soc_pkg.sv ====
// Bus types for a single-master AHB-lite fabric; only NONSEQ transfers carry data
package soc_pkg;

   // Data and address word
   typedef logic [31:0] word_t;

   // Byte lane enables, one bit per byte of word_t
   typedef logic [3:0] be_t;

   // AHB transfer type
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,   // Treated as idle
      NONSEQ = 2'b10,
      SEQ    = 2'b11    // Treated as idle
   } htrans_t;

   // AHB transfer size, larger codes are illegal here
   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_t;

   // Decoded target of an address phase
   typedef enum logic [1:0] {
      REG_TCM0 = 2'b00,
      REG_TCM1 = 2'b01,
      REG_GPIO = 2'b10,
      REG_NONE = 2'b11   // Unmapped or illegal size
   } region_t;

endpackage

// ==== include/soc_params.svh ====
// Address map assumes 32-bit byte addresses and RAM banks aligned on their own size
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// RAM banks
`define SOC_TCM_AW       16             // Byte address bits per bank, 64 KB
`define SOC_TCM0_BASE    32'h0000_0000  // Bank 0
`define SOC_TCM1_BASE    32'h0001_0000  // Bank 1, differs from bank 0 in bit 16

// GPIO window
`define SOC_GPIO_BASE    32'h2000_0000
`define SOC_GPIO_WIN_AW  12             // 4 KB window

// Register offsets inside the GPIO window
`define SOC_GPIO_OUT_OFS 12'h000        // Output register, drives P0
`define SOC_GPIO_IN_OFS  12'h004        // Synchronized P1, read only

// Port width, both directions
`define SOC_GPIO_W       16

`endif
